// ==== common/acq_pkg.sv ====
package acq_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Stream sample width
    localparam int DATA_W = 64;
    // Configuration register width
    localparam int REG_W = 32;
    // Register index width
    localparam int CFG_ADDR_W = 4;
    // Announced window length, truncated
    localparam int ACQ_LEN_OUT_W = 20;

    // ----------------------------------------
    // Register map
    // ----------------------------------------

    // Index 2n is acquire length of window n, index 2n+1 its drop length
    localparam int WINDOWS = 4;
    // Bit 0 of this index holds the soft reset
    localparam int SOFT_RESET_ADDR = 8;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [DATA_W-1:0] sample_t;
    typedef logic [REG_W-1:0] len_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [1:0] win_idx_t;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_DROP  = 2'd1,
        ST_ACQ   = 2'd2,
        ST_ERROR = 2'd3
    } acq_state_t;

endpackage

// ==== hdl/acq_trigger.sv ====
`timescale 1ns/1ps

module acq_trigger (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               cfg_wr,
    input  acq_pkg::cfg_addr_t                 cfg_addr,
    input  acq_pkg::len_t                      cfg_wdata,
    input  acq_pkg::sample_t                   s_axis_tdata,
    input  logic                               s_axis_tvalid,
    output logic                               s_axis_tready,
    output acq_pkg::sample_t                   m_axis_tdata,
    output logic                               m_axis_tvalid,
    input  logic                               m_axis_tready,
    input  logic                               gate,
    output logic                               resetn_out,
    output logic                               gate_out,
    output logic [acq_pkg::ACQ_LEN_OUT_W-1:0] acq_len_out,
    output acq_pkg::acq_state_t                state
);

    import acq_pkg::*;

    // Register bank outputs
    len_t acq_len [WINDOWS];
    len_t drop_len [WINDOWS];
    logic soft_reset;

    // Window store to controller
    len_t     acq0_live;
    len_t     drop0_live;
    len_t     cur_acq;
    len_t     cur_drop;
    win_idx_t win_idx;

    // Controller to counter
    logic cnt_load;
    len_t cnt_len;
    logic beat;
    logic last;

    // Input side never back-pressures
    assign s_axis_tready = 1'b1;

    cfg_regs u_cfg_regs (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .acq_len    (acq_len),
        .drop_len   (drop_len),
        .soft_reset (soft_reset),
        .resetn_out (resetn_out)
    );

    window_store u_window_store (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .soft_reset (soft_reset),
        .gate       (gate),
        .acq_len    (acq_len),
        .drop_len   (drop_len),
        .win_idx    (win_idx),
        .acq0_live  (acq0_live),
        .drop0_live (drop0_live),
        .cur_acq    (cur_acq),
        .cur_drop   (cur_drop)
    );

    sample_counter u_sample_counter (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .soft_reset (soft_reset),
        .cnt_load   (cnt_load),
        .cnt_len    (cnt_len),
        .beat       (beat),
        .last       (last)
    );

    acq_ctrl u_acq_ctrl (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .soft_reset    (soft_reset),
        .gate          (gate),
        .acq0_live     (acq0_live),
        .drop0_live    (drop0_live),
        .cur_acq       (cur_acq),
        .cur_drop      (cur_drop),
        .last          (last),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .m_axis_tready (m_axis_tready),
        .win_idx       (win_idx),
        .cnt_load      (cnt_load),
        .cnt_len       (cnt_len),
        .beat          (beat),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .gate_out      (gate_out),
        .acq_len_out   (acq_len_out),
        .state         (state)
    );

endmodule

// ==== hdl/cfg_regs.sv ====
`timescale 1ns/1ps

module cfg_regs (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              cfg_wr,
    input  acq_pkg::cfg_addr_t cfg_addr,
    input  acq_pkg::len_t     cfg_wdata,
    output acq_pkg::len_t     acq_len [acq_pkg::WINDOWS],
    output acq_pkg::len_t     drop_len [acq_pkg::WINDOWS],
    output logic              soft_reset,
    output logic              resetn_out
);

    import acq_pkg::*;

    // Window table, two words per window
    len_t acq_q [WINDOWS];
    len_t drop_q [WINDOWS];
    // Soft reset bit
    logic soft_q;

    // ----------------------------------------
    // Strobe write port
    // ----------------------------------------

    // Only the hard reset clears the bank, the soft reset bit must survive itself
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < WINDOWS; i++) begin
                acq_q[i]  <= '0;
                drop_q[i] <= '0;
            end
            soft_q <= 1'b0;
        end else if (cfg_wr) begin
            for (int i = 0; i < WINDOWS; i++) begin
                if (cfg_addr == cfg_addr_t'(2 * i)) begin
                    acq_q[i] <= cfg_wdata;
                end
                if (cfg_addr == cfg_addr_t'(2 * i + 1)) begin
                    drop_q[i] <= cfg_wdata;
                end
            end
            // Indices above the soft reset word fall through untouched
            if (cfg_addr == cfg_addr_t'(SOFT_RESET_ADDR)) begin
                soft_q <= cfg_wdata[0];
            end
        end
    end

    assign acq_len  = acq_q;
    assign drop_len = drop_q;

    // Soft reset fans out to the sequencing logic
    assign soft_reset = soft_q;
    // Downstream reset, low on either source
    assign resetn_out = aresetn && !soft_q;

    // Strobe must be clean once out of reset
    assert property (@(posedge aclk) disable iff (!aresetn) !$isunknown(cfg_wr))
        else $error("cfg_wr is unknown");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Some tests failed"

verilator --binary --assert -Wno-fatal --top-module tb_acq_trigger \
    --Mdir obj_dir -o tb_acq_trigger -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_acq_trigger > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

// ==== sim.f ====
common/acq_pkg.sv
hdl/cfg_regs.sv
trigger/window_store.sv
trigger/sample_counter.sv
trigger/acq_ctrl.sv
hdl/acq_trigger.sv
testbench/tb_acq_trigger.sv

// ==== testbench/acq_vectors.txt ====
# W addr value | G | B beats stall_beat (-1 none) | L expected gate_out length
# R expected resetn_out | E forwarded_count first_index state (0 idle, 3 error)
# Single window
W 0 5
W 1 3
G
B 12 -1
L 5
E 5 3 0
# Multiple windows
W 0 3
W 1 2
W 2 2
W 3 0
W 4 1
W 5 4
W 6 0
G
B 16 -1
L 3
L 2
L 1
E 6 2 0
# Zero start
W 0 0
G
B 4 -1
E 0 0 0
# Back-pressure
W 0 4
W 1 1
G
B 8 3
L 4
E 6 1 3
G
B 3 -1
E 3 0 3
# Soft reset
W 8 1
R 0
E 0 0 0
W 8 0
R 1
W 0 5
W 1 3
W 2 0
G
B 12 -1
L 5
E 5 3 0

// ==== testbench/tb_acq_trigger.sv ====
`timescale 1ns/1ps

module tb_acq_trigger;

    import acq_pkg::*;

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic                     aclk;
    logic                     aresetn;
    logic                     cfg_wr;
    cfg_addr_t                cfg_addr;
    len_t                     cfg_wdata;
    sample_t                  s_axis_tdata;
    logic                     s_axis_tvalid;
    logic                     s_axis_tready;
    sample_t                  m_axis_tdata;
    logic                     m_axis_tvalid;
    logic                     m_axis_tready;
    logic                     gate;
    logic                     resetn_out;
    logic                     gate_out;
    logic [ACQ_LEN_OUT_W-1:0] acq_len_out;
    acq_state_t               state;

    // Beat data source
    int seed = 93131;
    // Beats sent since the last expectation record and the one on the bus
    sample_t sent_q [$];
    int      beat_idx;
    // Monitor results
    len_t                     fwd_count;
    len_t                     first_idx;
    logic [ACQ_LEN_OUT_W-1:0] pulse_q [$];
    logic [ACQ_LEN_OUT_W-1:0] exp_pulse_q [$];

    acq_trigger uut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .gate          (gate),
        .resetn_out    (resetn_out),
        .gate_out      (gate_out),
        .acq_len_out   (acq_len_out),
        .state         (state)
    );

    // 100 ns period
    initial aclk = 1'b0;
    always #50 aclk = ~aclk;

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        fail_run();
    endtask

    task automatic check_count(input string name, input len_t exp, input len_t got);
        if (got !== exp) begin
            $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, got);
            fail_run();
        end
    endtask

    task automatic check_data(input string name, input sample_t exp, input sample_t got);
        if (got !== exp) begin
            $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
            fail_run();
        end
    endtask

    task automatic check_state(input string name, input acq_state_t exp, input acq_state_t got);
        if (got !== exp) begin
            $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, got);
            fail_run();
        end
    endtask

    task automatic check_len(input string name, input logic [ACQ_LEN_OUT_W-1:0] exp,
                             input logic [ACQ_LEN_OUT_W-1:0] got);
        if (got !== exp) begin
            $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, got);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error at time %0t: %s expected %b, got %b", $time, name, exp, got);
            fail_run();
        end
    endtask

    // ----------------------------------------
    // Monitor
    // ----------------------------------------

    // Inputs move on the falling edge, so values here are settled
    always @(posedge aclk) begin
        if (aresetn) begin
            // Input side never stalls the source
            check_bit("s_axis_tready", 1'b1, s_axis_tready);
            if (m_axis_tvalid && m_axis_tready) begin
                if (fwd_count == '0) begin
                    first_idx = len_t'(beat_idx);
                end
                // Data must pass through unchanged
                check_data("m_axis_tdata", sent_q[beat_idx], m_axis_tdata);
                fwd_count = fwd_count + 1;
            end
            if (gate_out) begin
                pulse_q.push_back(acq_len_out);
            end
        end
    end

    // ----------------------------------------
    // Drivers called on a falling edge
    // ----------------------------------------

    task automatic write_reg(input int addr, input int value);
        cfg_addr  = cfg_addr_t'(addr);
        cfg_wdata = len_t'(value);
        cfg_wr    = 1'b1;
        @(negedge aclk);
        cfg_wr    = 1'b0;
    endtask

    task automatic pulse_gate();
        gate = 1'b1;
        @(negedge aclk);
        gate = 1'b0;
    endtask

    // One beat per cycle with tready dropped only for beat stall_at
    task automatic send_burst(input int beats, input int stall_at);
        sample_t data;
        for (int i = 0; i < beats; i++) begin
            data = {$random(seed), $random(seed)};
            sent_q.push_back(data);
            beat_idx      = sent_q.size() - 1;
            s_axis_tdata  = data;
            s_axis_tvalid = 1'b1;
            m_axis_tready = (i != stall_at);
            @(negedge aclk);
        end
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
    endtask

    // A sequence is over once the state leaves drop and acquire
    task automatic wait_settled();
        int cycles;
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("the sequence to return to idle or error");
            end
        end while (state == ST_DROP || state == ST_ACQ);
    endtask

    task automatic check_results(input int count, input int first, input int st);
        wait_settled();
        check_count("forwarded beat count", len_t'(count), fwd_count);
        if (count > 0) begin
            check_count("first forwarded beat", len_t'(first), first_idx);
        end
        check_state("state", acq_state_t'(st), state);
        check_count("gate_out pulses", len_t'(exp_pulse_q.size()), len_t'(pulse_q.size()));
        foreach (exp_pulse_q[i]) begin
            check_len("acq_len_out", exp_pulse_q[i], pulse_q[i]);
        end
        // Next record counts from zero
        fwd_count = '0;
        first_idx = '0;
        beat_idx  = 0;
        sent_q.delete();
        pulse_q.delete();
        exp_pulse_q.delete();
    endtask

    task automatic read_arg(input int fd, output int value);
        if ($fscanf(fd, "%d", value) != 1) begin
            $display("Missing number on a line of the vector file");
            fail_run();
        end
    endtask

    // ----------------------------------------
    // Command loop
    // ----------------------------------------

    initial begin
        int              fd;
        int              code;
        int              arg_a;
        int              arg_b;
        int              arg_c;
        logic [8*8-1:0]  cmd;
        logic [8*80-1:0] rest;
        logic            running;
        cfg_wr        = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        gate          = 1'b0;
        aresetn       = 1'b0;
        fwd_count     = '0;
        first_idx     = '0;
        beat_idx      = 0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        fd = $fopen("testbench/acq_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/acq_vectors.txt");
            fail_run();
        end
        running = 1'b1;
        while (running) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                running = 1'b0;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else if (cmd == "W") begin
                read_arg(fd, arg_a);
                read_arg(fd, arg_b);
                write_reg(arg_a, arg_b);
            end else if (cmd == "G") begin
                pulse_gate();
            end else if (cmd == "B") begin
                read_arg(fd, arg_a);
                read_arg(fd, arg_b);
                send_burst(arg_a, arg_b);
            end else if (cmd == "L") begin
                read_arg(fd, arg_a);
                exp_pulse_q.push_back(arg_a[ACQ_LEN_OUT_W-1:0]);
            end else if (cmd == "R") begin
                read_arg(fd, arg_a);
                check_bit("resetn_out", arg_a[0], resetn_out);
            end else if (cmd == "E") begin
                read_arg(fd, arg_a);
                read_arg(fd, arg_b);
                read_arg(fd, arg_c);
                check_results(arg_a, arg_b, arg_c);
            end else begin
                $display("Unknown command in the vector file");
                fail_run();
            end
        end
        $fclose(fd);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== trigger/acq_ctrl.sv ====
`timescale 1ns/1ps

module acq_ctrl (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               soft_reset,
    input  logic                               gate,
    input  acq_pkg::len_t                      acq0_live,
    input  acq_pkg::len_t                      drop0_live,
    input  acq_pkg::len_t                      cur_acq,
    input  acq_pkg::len_t                      cur_drop,
    input  logic                               last,
    input  logic                               s_axis_tvalid,
    input  acq_pkg::sample_t                   s_axis_tdata,
    input  logic                               m_axis_tready,
    output acq_pkg::win_idx_t                  win_idx,
    output logic                               cnt_load,
    output acq_pkg::len_t                      cnt_len,
    output logic                               beat,
    output logic                               m_axis_tvalid,
    output acq_pkg::sample_t                   m_axis_tdata,
    output logic                               gate_out,
    output logic [acq_pkg::ACQ_LEN_OUT_W-1:0] acq_len_out,
    output acq_pkg::acq_state_t                state
);

    import acq_pkg::*;

    acq_state_t state_q, state_d;
    // Window index advances on entry to acquire
    win_idx_t win_q, win_d;
    // Set while acquiring the final table entry
    logic last_win_q, last_win_d;
    logic gate_out_q, gate_out_d;
    logic [ACQ_LEN_OUT_W-1:0] acq_len_q, acq_len_d;

    // ----------------------------------------
    // State registers
    // ----------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn || soft_reset) begin
            state_q    <= ST_IDLE;
            win_q      <= '0;
            last_win_q <= 1'b0;
            gate_out_q <= 1'b0;
            acq_len_q  <= '0;
        end else begin
            state_q    <= state_d;
            win_q      <= win_d;
            last_win_q <= last_win_d;
            gate_out_q <= gate_out_d;
            acq_len_q  <= acq_len_d;
        end
    end

    // ----------------------------------------
    // Next state and counter scheduling
    // ----------------------------------------

    always_comb begin
        state_d    = state_q;
        win_d      = win_q;
        last_win_d = last_win_q;
        gate_out_d = 1'b0;
        acq_len_d  = acq_len_q;
        cnt_load   = 1'b0;
        cnt_len    = '0;
        case (state_q)
            ST_IDLE: begin
                // Empty first window means nothing to do
                if (gate && acq0_live != '0) begin
                    state_d    = ST_DROP;
                    win_d      = '0;
                    last_win_d = 1'b0;
                    gate_out_d = 1'b1;
                    acq_len_d  = acq0_live[ACQ_LEN_OUT_W-1:0];
                    // Snapshot not yet valid so the live drop length is used
                    cnt_load   = (drop0_live != '0);
                    cnt_len    = drop0_live;
                end
            end
            ST_DROP: begin
                // Zero drop takes a single idle cycle
                if (cur_drop == '0 || (beat && last)) begin
                    state_d    = ST_ACQ;
                    win_d      = win_q + 1'b1;
                    last_win_d = (win_q == win_idx_t'(WINDOWS - 1));
                    cnt_load   = 1'b1;
                    cnt_len    = cur_acq;
                end
            end
            ST_ACQ: begin
                // Stall while open is fatal as window content would be lost
                if (s_axis_tvalid && !m_axis_tready) begin
                    state_d = ST_ERROR;
                end else if (beat && last) begin
                    // cur_* already point at the next window here
                    if (last_win_q || cur_acq == '0) begin
                        state_d = ST_IDLE;
                    end else begin
                        state_d    = ST_DROP;
                        gate_out_d = 1'b1;
                        acq_len_d  = cur_acq[ACQ_LEN_OUT_W-1:0];
                        cnt_load   = (cur_drop != '0);
                        cnt_len    = cur_drop;
                    end
                end
            end
            // Sticky until reset
            ST_ERROR: state_d = ST_ERROR;
            default: state_d = ST_IDLE;
        endcase
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    // Counted beats exclude a zero length drop
    assign beat = s_axis_tvalid &&
        (state_q == ST_ACQ || (state_q == ST_DROP && cur_drop != '0));

    // Error keeps forwarding so a transfer in flight can finish
    assign m_axis_tvalid = s_axis_tvalid && (state_q == ST_ACQ || state_q == ST_ERROR);
    assign m_axis_tdata  = s_axis_tdata;

    assign win_idx     = win_q;
    assign gate_out    = gate_out_q;
    assign acq_len_out = acq_len_q;
    assign state       = state_q;

    // Window announcement is a single cycle pulse
    assert property (@(posedge aclk) disable iff (!aresetn || soft_reset)
        gate_out |=> !gate_out)
        else $error("gate_out longer than one cycle");

endmodule

// ==== trigger/sample_counter.sv ====
`timescale 1ns/1ps

module sample_counter (
    input  logic          aclk,
    input  logic          aresetn,
    input  logic          soft_reset,
    input  logic          cnt_load,
    input  acq_pkg::len_t cnt_len,
    input  logic          beat,
    output logic          last
);

    import acq_pkg::*;

    // Run length minus one
    len_t len_m1_q;
    // Beats seen since the last load
    len_t count_q;

    // ----------------------------------------
    // Beat counter
    // ----------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn || soft_reset) begin
            len_m1_q <= '0;
            count_q  <= '0;
        end else if (cnt_load) begin
            // Load wins over a coincident beat, that beat ends the previous run
            len_m1_q <= cnt_len - 1'b1;
            count_q  <= '0;
        end else if (beat) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Final beat of the run, qualified by beat in the controller
    assign last = (count_q == len_m1_q);

    // Controller skips zero length runs instead of loading them
    assert property (@(posedge aclk) disable iff (!aresetn || soft_reset)
        cnt_load |-> (cnt_len != '0))
        else $error("counter loaded with zero length");

endmodule

// ==== trigger/window_store.sv ====
`timescale 1ns/1ps

module window_store (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              soft_reset,
    input  logic              gate,
    input  acq_pkg::len_t     acq_len [acq_pkg::WINDOWS],
    input  acq_pkg::len_t     drop_len [acq_pkg::WINDOWS],
    input  acq_pkg::win_idx_t win_idx,
    output acq_pkg::len_t     acq0_live,
    output acq_pkg::len_t     drop0_live,
    output acq_pkg::len_t     cur_acq,
    output acq_pkg::len_t     cur_drop
);

    import acq_pkg::*;

    // Snapshot of the window table
    len_t acq_q [WINDOWS];
    len_t drop_q [WINDOWS];

    // ----------------------------------------
    // Snapshot on gate
    // ----------------------------------------

    // Register rewrites during a running sequence do not disturb it
    always_ff @(posedge aclk) begin
        if (!aresetn || soft_reset) begin
            for (int i = 0; i < WINDOWS; i++) begin
                acq_q[i]  <= '0;
                drop_q[i] <= '0;
            end
        end else if (gate) begin
            acq_q  <= acq_len;
            drop_q <= drop_len;
        end
    end

    // Window 0 straight from the registers, needed at the gate edge itself
    assign acq0_live  = acq_len[0];
    assign drop0_live = drop_len[0];

    // Entry picked by the controller
    assign cur_acq  = acq_q[win_idx];
    assign cur_drop = drop_q[win_idx];

endmodule
